/* scope_ctrl_cmd_pkg.sv */
// serial command set
package scope_ctrl_cmd_pkg;

	// ranged board codes, each range is CODE_SPAN wide
	localparam logic [7:0] CODE_SPAN    = 8'd10; // board ids 0..9 sit below this
	localparam logic [7:0] ID_LAST_BASE = 8'd20; // 20+id marks the last board
	localparam logic [7:0] ACTIVE_BASE  = 8'd30; // 30+id picks the board that answers

	localparam logic [7:0] CMD_PRIME    = 8'd100; // arm the trigger on every board
	localparam logic [7:0] CMD_ROLL_ON  = 8'd101;
	localparam logic [7:0] CMD_ROLL_OFF = 8'd102;
	localparam logic [7:0] CMD_TRIGPT   = 8'd121; // two bytes, trigger point
	localparam logic [7:0] CMD_NSEND    = 8'd122; // two bytes, samples to send
	localparam logic [7:0] CMD_THRESH   = 8'd127; // low trigger threshold
	localparam logic [7:0] CMD_TRIGTYPE = 8'd128;
	localparam logic [7:0] CMD_TRIGCHAN = 8'd130; // toggles one channel enable
	localparam logic [7:0] CMD_DELAYCNT = 8'd132; // reply with tdc delay count
	localparam logic [7:0] CMD_CARRYCNT = 8'd133; // reply with tdc carry count
	localparam logic [7:0] CMD_THRESH2  = 8'd140; // high trigger threshold
	localparam logic [7:0] CMD_CHIPID   = 8'd142; // reply with the 8 byte unique id

	localparam int MAX_ARGS = 2;
	localparam int ARGCNT_W = $clog2(MAX_ARGS + 1);

	// argument bytes as they arrive, or as one number
	typedef union packed {
		logic [1:0][7:0] bytes; // [1] first of two bytes, [0] last or only byte
		logic [15:0]     word;
	} arg_word_u;

	function automatic logic [ARGCNT_W-1:0] arg_count(input logic [7:0] code);
		case (code)
			CMD_TRIGPT, CMD_NSEND: arg_count = ARGCNT_W'(MAX_ARGS);
			CMD_THRESH, CMD_TRIGTYPE, CMD_TRIGCHAN, CMD_THRESH2: arg_count = ARGCNT_W'(1);
			default: arg_count = '0; // no arguments, or not a command we know
		endcase
	endfunction

	function automatic logic is_reply(input logic [7:0] code);
		is_reply = (code == CMD_DELAYCNT) || (code == CMD_CARRYCNT) || (code == CMD_CHIPID);
	endfunction

endpackage

/* scope_ctrl_cfg_pkg.sv */
// board limits and defaults
package scope_ctrl_cfg_pkg;

	localparam int RAM_WIDTH      = 12; // sample address width, 4096 samples
	localparam int CHAN_PER_BOARD = 4;
	localparam int CHAN_IDX_W     = $clog2(CHAN_PER_BOARD);
	localparam int CHIP_ID_BYTES  = 8;
	localparam int CHIP_ID_W      = 8 * CHIP_ID_BYTES;
	localparam int BYTE_CNT_W     = $clog2(CHIP_ID_BYTES + 1);

	// trigger point window inside the sample ram
	localparam logic [RAM_WIDTH-1:0] TRIGPT_MIN   = RAM_WIDTH'(4);
	localparam logic [RAM_WIDTH-1:0] TRIGPT_MAX   = RAM_WIDTH'(2**RAM_WIDTH - 16);
	localparam logic [RAM_WIDTH-1:0] NSEND_MARGIN = RAM_WIDTH'(5); // samples kept after trigger

	// values after reset
	localparam logic [RAM_WIDTH-1:0]      TRIGPT_RST   = RAM_WIDTH'(2**(RAM_WIDTH-2)); // 1/4
	localparam logic [7:0]                THRESH_RST   = 8'h80;
	localparam logic [7:0]                THRESH2_RST  = 8'hFF;
	localparam logic [CHAN_PER_BOARD-1:0] TRIGCHAN_RST = '1; // all channels trigger
	localparam logic [3:0]                TRIGTYPE_RST = 4'b0001; // rising edge only
	localparam logic                      ROLLING_RST  = 1'b1;
	localparam logic [7:0]                MYID_RST     = 8'd200; // no id given yet

	// clock source of this board
	localparam logic [1:0] MCLK_SELF  = 2'b00; // own oscillator
	localparam logic [1:0] MCLK_CHAIN = 2'b01; // clock from the previous board

	// what the reply sender streams out
	localparam logic [1:0] REPLY_DELAY  = 2'd0;
	localparam logic [1:0] REPLY_CARRY  = 2'd1;
	localparam logic [1:0] REPLY_CHIPID = 2'd2;

endpackage

/* cmd_receiver.sv */
// command byte collector
`timescale 1ns/1ns
module cmd_receiver
	import scope_ctrl_cmd_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       rxReady,    // one cycle strobe from the uart receiver
	input  logic [7:0] rxData,
	input  logic       reply_busy, // bytes arriving during a reply are dropped
	output logic       op_valid,
	output logic [7:0] op_code,
	output logic       arg_valid,
	output logic [7:0] arg_byte,
	output logic       cmd_done,   // opcode and all its arguments are in
	output logic [7:0] cmd_code,
	output arg_word_u  cmd_arg
);

	logic [ARGCNT_W-1:0] args_left;  // argument bytes still expected
	logic                collecting; // next byte is an argument, not an opcode
	logic                take;

	assign take = rxReady & ~reply_busy;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			op_valid   <= 1'b0;
			arg_valid  <= 1'b0;
			cmd_done   <= 1'b0;
			collecting <= 1'b0;
			args_left  <= '0;
		end else begin
			op_valid  <= 1'b0; // all three are single cycle pulses
			arg_valid <= 1'b0;
			cmd_done  <= 1'b0;
			if (op_valid && !collecting)
				cmd_done <= 1'b1; // command without arguments finishes right away
			if (take) begin
				if (!collecting) begin
					op_valid   <= 1'b1;
					args_left  <= arg_count(rxData);
					collecting <= (arg_count(rxData) != '0);
				end else begin
					arg_valid <= 1'b1;
					args_left <= args_left - 1'b1;
					if (args_left == ARGCNT_W'(1)) begin // last argument byte
						collecting <= 1'b0;
						cmd_done   <= 1'b1;
					end
				end
			end
		end
	end

	// opcode and argument bytes
	always_ff @(posedge clk) begin
		if (take && !collecting) begin
			op_code  <= rxData;
			cmd_code <= rxData;
			cmd_arg  <= '0; // short arguments leave the high byte clear
		end else if (take) begin
			arg_byte <= rxData;
			if (args_left == ARGCNT_W'(MAX_ARGS))
				cmd_arg.bytes[1] <= rxData; // high byte comes first
			else
				cmd_arg.bytes[0] <= rxData;
		end
	end

endmodule

/* chain_relay.sv */
// daisy chain relay and board identity
`timescale 1ns/1ns
module chain_relay
	import scope_ctrl_cmd_pkg::*;
	import scope_ctrl_cfg_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       op_valid,
	input  logic [7:0] op_code,
	input  logic       arg_valid,
	input  logic [7:0] arg_byte,
	input  logic       cmd_done,
	input  logic [7:0] cmd_code,
	output logic [7:0] comdata,            // byte for the next board
	output logic       newcomdata,         // one cycle strobe with comdata
	output logic       serial_passthrough, // another board is answering
	output logic       imthelast,
	output logic [1:0] master_clock,
	output logic       imthefirst,
	output logic [7:0] my_id,
	output logic       reply_req,
	output logic [1:0] reply_sel
);

	logic [7:0] last_off;   // opcode offset into the last board range
	logic [7:0] active_off; // opcode offset into the active board range
	logic       is_id;
	logic       is_last;
	logic       is_active;
	logic       is_trig;

	assign last_off   = op_code - ID_LAST_BASE;
	assign active_off = op_code - ACTIVE_BASE;
	assign is_id      = (op_code < CODE_SPAN);
	assign is_last    = (last_off < CODE_SPAN);   // codes below the base wrap high
	assign is_active  = (active_off < CODE_SPAN);
	assign is_trig    = (op_code == CMD_PRIME) || (op_code == CMD_ROLL_ON) ||
	                    (op_code == CMD_ROLL_OFF);

	assign imthefirst = (my_id == 8'd0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			newcomdata         <= 1'b0;
			serial_passthrough <= 1'b0;
			imthelast          <= 1'b0;
			master_clock       <= MCLK_SELF;
			my_id              <= MYID_RST;
			reply_req          <= 1'b0;
		end else begin
			newcomdata <= 1'b0;
			reply_req  <= 1'b0;
			if (op_valid) begin
				if (is_id) begin
					my_id        <= op_code;
					master_clock <= (op_code == 8'd0) ? MCLK_SELF : MCLK_CHAIN;
					newcomdata   <= 1'b1; // next board gets id+1
				end else if (is_last) begin
					imthelast  <= (last_off == my_id);
					newcomdata <= 1'b1;
				end else if (is_active) begin
					serial_passthrough <= (active_off != my_id);
					newcomdata         <= (active_off != my_id); // selecting us stops here
				end else if (is_trig || (arg_count(op_code) != '0)) begin
					newcomdata <= 1'b1; // trigger and settings go to every board
				end else if (is_reply(op_code)) begin
					newcomdata <= serial_passthrough; // only when someone downstream answers
				end
			end
			if (arg_valid)
				newcomdata <= 1'b1;
			if (cmd_done && is_reply(cmd_code) && !serial_passthrough)
				reply_req <= 1'b1;
		end
	end

	// relayed byte and reply source
	always_ff @(posedge clk) begin
		if (op_valid)
			comdata <= is_id ? op_code + 8'd1 : op_code;
		else if (arg_valid)
			comdata <= arg_byte;
		if (cmd_done)
			reply_sel <= (cmd_code == CMD_DELAYCNT) ? REPLY_DELAY :
			             (cmd_code == CMD_CARRYCNT) ? REPLY_CARRY : REPLY_CHIPID;
	end

endmodule

/* acq_settings.sv */
// trigger and acquisition settings
`timescale 1ns/1ns
module acq_settings
	import scope_ctrl_cmd_pkg::*;
	import scope_ctrl_cfg_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      cmd_done,
	input  logic [7:0]                cmd_code,
	input  arg_word_u                 cmd_arg,
	input  logic [7:0]                my_id,
	output logic [RAM_WIDTH-1:0]      triggerpoint,  // samples kept before the trigger
	output logic [RAM_WIDTH-1:0]      samplestosend,
	output logic [7:0]                trigthresh,
	output logic [7:0]                trigthresh2,
	output logic [3:0]                triggertype,
	output logic [CHAN_PER_BOARD-1:0] trigchannels,
	output logic                      rollingtrigger,
	output logic                      get_ext_data   // one cycle, arms the trigger
);

	logic [RAM_WIDTH-1:0]  tp_clamped;  // requested trigger point inside the window
	logic [RAM_WIDTH-1:0]  nsend;
	logic [RAM_WIDTH-1:0]  tp_half;
	logic                  tp_too_late; // too few samples left after the trigger
	logic [7:0]            arg_lo;
	logic [CHAN_IDX_W-1:0] chan_idx;    // channel within the board
	logic                  chan_mine;

	assign arg_lo  = cmd_arg.bytes[0]; // one byte settings
	assign nsend   = cmd_arg.word[RAM_WIDTH-1:0];
	assign tp_half = nsend >> 1;
	assign tp_too_late = (nsend >= NSEND_MARGIN) && (triggerpoint > nsend - NSEND_MARGIN);

	assign tp_clamped = (cmd_arg.word > 16'(TRIGPT_MAX)) ? TRIGPT_MAX :
	                    (cmd_arg.word < 16'(TRIGPT_MIN)) ? TRIGPT_MIN :
	                    cmd_arg.word[RAM_WIDTH-1:0];

	assign chan_idx  = arg_lo[CHAN_IDX_W-1:0];
	assign chan_mine = ((arg_lo >> CHAN_IDX_W) == my_id); // global channel / 4 is board

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			triggerpoint   <= TRIGPT_RST;
			samplestosend  <= '0;
			trigthresh     <= THRESH_RST;
			trigthresh2    <= THRESH2_RST;
			triggertype    <= TRIGTYPE_RST;
			trigchannels   <= TRIGCHAN_RST;
			rollingtrigger <= ROLLING_RST;
			get_ext_data   <= 1'b0;
		end else begin
			get_ext_data <= 1'b0;
			if (cmd_done) begin
				case (cmd_code)
					CMD_PRIME:    get_ext_data   <= 1'b1;
					CMD_ROLL_ON:  rollingtrigger <= 1'b1;
					CMD_ROLL_OFF: rollingtrigger <= 1'b0;
					CMD_TRIGPT:   triggerpoint   <= tp_clamped;
					CMD_NSEND: begin
						samplestosend <= nsend;
						if (tp_too_late) // pull back to mid window, never below the floor
							triggerpoint <= (tp_half < TRIGPT_MIN) ? TRIGPT_MIN : tp_half;
					end
					CMD_THRESH:   trigthresh  <= arg_lo;
					CMD_TRIGTYPE: triggertype <= arg_lo[3:0];
					CMD_TRIGCHAN: begin
						if (chan_mine)
							trigchannels[chan_idx] <= ~trigchannels[chan_idx];
					end
					CMD_THRESH2:  trigthresh2 <= arg_lo;
					default: ; // other boards' codes and replies
				endcase
			end
		end
	end

endmodule

/* reply_sender.sv */
// reply byte streamer
`timescale 1ns/1ns
module reply_sender
	import scope_ctrl_cfg_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 reply_req,
	input  logic [1:0]           reply_sel,
	input  logic [7:0]           delaycounter,
	input  logic [7:0]           carrycounter,
	input  logic [CHIP_ID_W-1:0] chip_id,
	input  logic                 txBusy,     // uart transmitter still shifting
	output logic                 txStart,
	output logic [7:0]           txData,
	output logic                 reply_busy
);

	logic [CHIP_ID_W-1:0]  shreg;      // reply bytes, next one in the low byte
	logic [BYTE_CNT_W-1:0] bytes_left;

	assign txData = shreg[7:0];

	// send when idle, then one advance cycle per byte
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			txStart    <= 1'b0;
			reply_busy <= 1'b0;
			bytes_left <= '0;
		end else if (!reply_busy) begin
			txStart <= 1'b0;
			if (reply_req) begin
				reply_busy <= 1'b1;
				bytes_left <= (reply_sel == REPLY_CHIPID) ? BYTE_CNT_W'(CHIP_ID_BYTES) :
				                                            BYTE_CNT_W'(1);
			end
		end else if (txStart) begin
			txStart    <= 1'b0; // advance
			bytes_left <= bytes_left - 1'b1;
			if (bytes_left == BYTE_CNT_W'(1))
				reply_busy <= 1'b0;
		end else if (!txBusy) begin
			txStart <= 1'b1;
		end
	end

	// source snapshot taken at the request
	always_ff @(posedge clk) begin
		if (reply_req && !reply_busy) begin
			case (reply_sel)
				REPLY_DELAY: shreg <= CHIP_ID_W'(delaycounter);
				REPLY_CARRY: shreg <= CHIP_ID_W'(carrycounter);
				default:     shreg <= chip_id; // least significant byte leaves first
			endcase
		end else if (reply_busy && txStart) begin
			shreg <= shreg >> 8;
		end
	end

endmodule

/* scope_ctrl.sv */
// scope board command processor
`timescale 1ns/1ns
module scope_ctrl
	import scope_ctrl_cmd_pkg::*;
	import scope_ctrl_cfg_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      rxReady,
	input  logic [7:0]                rxData,
	input  logic                      txBusy,
	input  logic [7:0]                delaycounter, // tdc counts from the trigger logic
	input  logic [7:0]                carrycounter,
	input  logic [CHIP_ID_W-1:0]      chip_id,
	output logic                      txStart,
	output logic [7:0]                txData,
	output logic                      reply_busy,
	output logic [7:0]                comdata,
	output logic                      newcomdata,
	output logic                      serial_passthrough,
	output logic                      imthelast,
	output logic [1:0]                master_clock,
	output logic                      imthefirst,
	output logic [RAM_WIDTH-1:0]      triggerpoint,
	output logic [RAM_WIDTH-1:0]      samplestosend,
	output logic [7:0]                trigthresh,
	output logic [7:0]                trigthresh2,
	output logic [3:0]                triggertype,
	output logic [CHAN_PER_BOARD-1:0] trigchannels,
	output logic                      rollingtrigger,
	output logic                      get_ext_data
);

	logic       op_valid;  // receiver to relay
	logic [7:0] op_code;
	logic       arg_valid;
	logic [7:0] arg_byte;
	logic       cmd_done;  // receiver to relay and settings
	logic [7:0] cmd_code;
	arg_word_u  cmd_arg;
	logic [7:0] my_id;
	logic       reply_req; // relay to sender
	logic [1:0] reply_sel;

	cmd_receiver cmd_receiver_inst (
		.clk(clk), .rst_n(rst_n), .rxReady(rxReady), .rxData(rxData),
		.reply_busy(reply_busy), .op_valid(op_valid), .op_code(op_code),
		.arg_valid(arg_valid), .arg_byte(arg_byte), .cmd_done(cmd_done),
		.cmd_code(cmd_code), .cmd_arg(cmd_arg)
	);

	chain_relay chain_relay_inst (
		.clk(clk), .rst_n(rst_n), .op_valid(op_valid), .op_code(op_code),
		.arg_valid(arg_valid), .arg_byte(arg_byte), .cmd_done(cmd_done),
		.cmd_code(cmd_code), .comdata(comdata), .newcomdata(newcomdata),
		.serial_passthrough(serial_passthrough), .imthelast(imthelast),
		.master_clock(master_clock), .imthefirst(imthefirst), .my_id(my_id),
		.reply_req(reply_req), .reply_sel(reply_sel)
	);

	acq_settings acq_settings_inst (
		.clk(clk), .rst_n(rst_n), .cmd_done(cmd_done), .cmd_code(cmd_code),
		.cmd_arg(cmd_arg), .my_id(my_id), .triggerpoint(triggerpoint),
		.samplestosend(samplestosend), .trigthresh(trigthresh), .trigthresh2(trigthresh2),
		.triggertype(triggertype), .trigchannels(trigchannels),
		.rollingtrigger(rollingtrigger), .get_ext_data(get_ext_data)
	);

	reply_sender reply_sender_inst (
		.clk(clk), .rst_n(rst_n), .reply_req(reply_req), .reply_sel(reply_sel),
		.delaycounter(delaycounter), .carrycounter(carrycounter), .chip_id(chip_id),
		.txBusy(txBusy), .txStart(txStart), .txData(txData), .reply_busy(reply_busy)
	);

endmodule

/* scope_ctrl_chk.sv */
// command processor assertions
`timescale 1ns/1ns
module scope_ctrl_chk
	import scope_ctrl_cfg_pkg::*;
(
	input logic                 clk,
	input logic                 rst_n,
	input logic                 txStart,
	input logic                 txBusy,
	input logic                 newcomdata,
	input logic                 get_ext_data,
	input logic [RAM_WIDTH-1:0] triggerpoint
);

	// strobes last exactly one cycle
	a_txstart_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		txStart |=> !txStart) else $error("txStart held for more than one cycle");
	a_newcom_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		newcomdata |=> !newcomdata) else $error("newcomdata held for more than one cycle");
	a_prime_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		get_ext_data |=> !get_ext_data) else $error("get_ext_data held too long");

	a_trigpt_window: assert property (@(posedge clk) disable iff (!rst_n)
		(triggerpoint >= TRIGPT_MIN) && (triggerpoint <= TRIGPT_MAX))
		else $error("triggerpoint %0d outside the clamp window", triggerpoint);

	// a new byte only once the transmitter is free
	a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(txStart) |-> !$past(txBusy)) else $error("txStart rose while txBusy was high");

endmodule

bind scope_ctrl scope_ctrl_chk scope_ctrl_chk_inst (
	.clk(clk), .rst_n(rst_n), .txStart(txStart), .txBusy(txBusy),
	.newcomdata(newcomdata), .get_ext_data(get_ext_data), .triggerpoint(triggerpoint)
);

/* tb_scope_ctrl.sv */
// command processor testbench
`timescale 1ns/1ns
module tb_scope_ctrl
	import scope_ctrl_cfg_pkg::*;
();

	localparam int CLK_HALF = 20;  // 40 ns period
	localparam int NREC     = 128; // room for more records than the data file holds
	localparam int WAIT_MAX = 100; // cycles before any wait gives up
	localparam logic [CHIP_ID_W-1:0] CHIP_ID_VAL = 64'h0123_4567_89AB_CDEF;
	localparam logic [7:0] DELAY_VAL = 8'h5A;
	localparam logic [7:0] CARRY_VAL = 8'hC3;

	logic                      clk;
	logic                      rst_n;
	logic                      rxReady;
	logic [7:0]                rxData;
	logic                      txBusy = 1'b0; // uart transmitter model
	logic                      txStart;
	logic [7:0]                txData;
	logic                      reply_busy;
	logic [7:0]                comdata;
	logic                      newcomdata;
	logic                      serial_passthrough;
	logic                      imthelast;
	logic [1:0]                master_clock;
	logic                      imthefirst;
	logic [RAM_WIDTH-1:0]      triggerpoint;
	logic [RAM_WIDTH-1:0]      samplestosend;
	logic [7:0]                trigthresh;
	logic [7:0]                trigthresh2;
	logic [3:0]                triggertype;
	logic [CHAN_PER_BOARD-1:0] trigchannels;
	logic                      rollingtrigger;
	logic                      get_ext_data;

	logic [23:0] recs [0:NREC-1];  // kind, setting select, value
	logic [7:0]  fwd_mem [0:255];  // relayed bytes in arrival order
	logic [7:0]  tx_mem [0:255];   // reply bytes in arrival order
	logic        tx_rb_mem [0:255]; // reply_busy seen with each reply byte
	int          fwd_wr = 0;
	int          tx_wr = 0;
	int          ext_cnt = 0;      // get_ext_data pulses seen
	int          fwd_rd = 0;
	int          tx_rd = 0;
	int          ext_rd = 0;
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;
	int          test_base = 0;    // error count when the current test began
	logic        timed_out = 1'b0;
	logic [7:0]  lfsr = 8'd67;
	logic [2:0]  busy_left;
	string       set_names [0:11] = '{"triggerpoint", "samplestosend", "trigthresh",
		"trigthresh2", "triggertype", "trigchannels", "rollingtrigger", "master_clock",
		"imthefirst", "serial_passthrough", "imthelast", "prime pulses"};

	scope_ctrl scope_ctrl_inst (
		.clk(clk), .rst_n(rst_n), .rxReady(rxReady), .rxData(rxData), .txBusy(txBusy),
		.delaycounter(DELAY_VAL), .carrycounter(CARRY_VAL), .chip_id(CHIP_ID_VAL),
		.txStart(txStart), .txData(txData), .reply_busy(reply_busy), .comdata(comdata),
		.newcomdata(newcomdata), .serial_passthrough(serial_passthrough),
		.imthelast(imthelast), .master_clock(master_clock), .imthefirst(imthefirst),
		.triggerpoint(triggerpoint), .samplestosend(samplestosend),
		.trigthresh(trigthresh), .trigthresh2(trigthresh2), .triggertype(triggertype),
		.trigchannels(trigchannels), .rollingtrigger(rollingtrigger),
		.get_ext_data(get_ext_data)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_HALF) clk = ~clk;
	end

	// galois lfsr with taps 8 6 5 4
	function automatic logic [7:0] lfsr_step(input logic [7:0] s);
		lfsr_step = s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
	endfunction

	// transmitter stays busy 1 to 8 cycles after each start
	always @(posedge clk) begin : busy_model
		logic [2:0] extra;
		int         b;
		extra = '0;
		if (!rst_n) begin
			txBusy <= 1'b0;
		end else if (txStart) begin
			for (b = 0; b < 3; b++) begin
				lfsr  = lfsr_step(lfsr); // one step per bit taken
				extra = {extra[1:0], lfsr[0]};
			end
			busy_left <= extra;
			txBusy    <= 1'b1;
		end else if (txBusy) begin
			if (busy_left == 3'd0)
				txBusy <= 1'b0;
			else
				busy_left <= busy_left - 3'd1;
		end
	end

	// collect relayed bytes, reply bytes and prime pulses
	always @(posedge clk) begin
		if (rst_n && newcomdata) begin
			fwd_mem[fwd_wr[7:0]] <= comdata;
			fwd_wr <= fwd_wr + 1;
		end
		if (rst_n && txStart) begin
			tx_mem[tx_wr[7:0]]    <= txData;
			tx_rb_mem[tx_wr[7:0]] <= reply_busy;
			tx_wr <= tx_wr + 1;
		end
		if (rst_n && get_ext_data)
			ext_cnt <= ext_cnt + 1;
	end

	function automatic logic [15:0] setting_value(input logic [3:0] sel);
		case (sel)
			4'h0: setting_value = 16'(triggerpoint);
			4'h1: setting_value = 16'(samplestosend);
			4'h2: setting_value = 16'(trigthresh);
			4'h3: setting_value = 16'(trigthresh2);
			4'h4: setting_value = 16'(triggertype);
			4'h5: setting_value = 16'(trigchannels);
			4'h6: setting_value = 16'(rollingtrigger);
			4'h7: setting_value = 16'(master_clock);
			4'h8: setting_value = 16'(imthefirst);
			4'h9: setting_value = 16'(serial_passthrough);
			4'hA: setting_value = 16'(imthelast);
			4'hB: setting_value = 16'(ext_cnt - ext_rd); // pulses since the last look
			default: setting_value = 16'hDEAD;
		endcase
	endfunction

	task automatic send_byte(input logic [7:0] b);
		int n;
		n = 0;
		while (reply_busy && n < WAIT_MAX) begin // receiver drops bytes during a reply
			@(posedge clk);
			n++;
		end
		if (reply_busy) begin
			$display("timeout: reply still running when byte %h was due", b);
			timed_out = 1'b1;
		end else begin
			@(posedge clk);
			rxReady <= 1'b1;
			rxData  <= b;
			@(posedge clk);
			rxReady <= 1'b0;
			repeat (4) @(posedge clk); // strobe spacing
		end
	endtask

	// next relayed byte, or next reply byte when is_tx
	task automatic expect_byte(input logic is_tx, input logic [7:0] e);
		int         n;
		logic [7:0] got;
		n = 0;
		@(negedge clk);
		while ((is_tx ? tx_rd == tx_wr : fwd_rd == fwd_wr) && n < WAIT_MAX) begin
			@(negedge clk);
			n++;
		end
		if (is_tx ? tx_rd == tx_wr : fwd_rd == fwd_wr) begin
			$display("timeout: no %s byte arrived, %h was expected",
			         is_tx ? "reply" : "relayed", e);
			timed_out = 1'b1;
		end else begin
			got = is_tx ? tx_mem[tx_rd[7:0]] : fwd_mem[fwd_rd[7:0]];
			checks++;
			if (got !== e) begin
				$display("FAILED at %0t ns: %s byte %h, expected %h", $time,
				         is_tx ? "reply" : "relayed", got, e);
				errors++;
			end
			if (is_tx && tx_rb_mem[tx_rd[7:0]] !== 1'b1) begin
				$display("FAILED at %0t ns: reply byte %h went out with reply_busy low",
				         $time, got);
				errors++;
			end
			if (is_tx)
				tx_rd++;
			else
				fwd_rd++;
		end
	endtask

	task automatic check_setting(input logic [3:0] sel, input logic [15:0] e);
		logic [15:0] got;
		@(negedge clk);
		got = setting_value(sel);
		checks++;
		if (got !== e) begin
			$display("FAILED at %0t ns: %s is %h, expected %h", $time,
			         (sel < 4'd12) ? set_names[sel] : "unknown setting", got, e);
			errors++;
		end
		if (sel == 4'hB)
			ext_rd = ext_cnt;
	endtask

	task automatic check_quiet();
		repeat (10) @(negedge clk); // window for a stray relay or reply
		checks++;
		if (fwd_rd != fwd_wr || tx_rd != tx_wr) begin
			$display("FAILED at %0t ns: byte relayed or replied where none was due", $time);
			errors++;
			fwd_rd = fwd_wr;
			tx_rd  = tx_wr;
		end
	endtask

	task automatic finish_test(input logic [15:0] num);
		@(negedge clk);
		if (fwd_rd != fwd_wr || tx_rd != tx_wr || reply_busy !== 1'b0) begin
			$display("FAILED at %0t ns: test %0d left stray bytes or a reply running",
			         $time, num);
			errors++;
		end
		tests++;
		$display("test %0d %s, %0d errors", num, (errors == test_base) ? "ok" : "failed",
		         errors - test_base);
		test_base = errors;
	endtask

	initial begin : main
		int          i;
		logic [23:0] r;
		rst_n   = 1'b0;
		rxReady = 1'b0;
		rxData  = 8'h00;
		$readmemh("scope_ctrl_testdata.txt", recs);
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk);
		i = 0;
		while (i < NREC && recs[i][23:20] != 4'hF && !timed_out) begin
			r = recs[i];
			case (r[23:20])
				4'h1: send_byte(r[7:0]);
				4'h2: expect_byte(1'b0, r[7:0]);
				4'h3: expect_byte(1'b1, r[7:0]);
				4'h4: check_setting(r[19:16], r[15:0]);
				4'h5: check_quiet();
				4'h0: finish_test(r[15:0]);
				default: begin
					$display("unreadable record %0d in the test data: %h", i, r);
					errors++;
				end
			endcase
			i++;
		end
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0 && !timed_out && tests > 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* scope_ctrl_testdata.txt */
// record KSVVVV hex: K kind, S setting select, VVVV value
// K 1 send, 2 relayed byte, 3 reply byte, 4 setting S, 5 quiet, 0 end of test VVVV, F end
// S 0 trigpt 1 nsend 2 thresh 3 thresh2 4 trigtype 5 trigchan 6 rolling 7 mclk
// S 8 first 9 passthrough A last B prime pulses since last look
100003 200004 470001 480000
100000 200001 470000 480001
000001
100002 200003 470001
100020 500000 490000
100023 200023 490001
100016 200016 4A0001
000002
100079 200079 100000 200000 100002 200002 400004
100079 200079 100013 200013 100088 200088 400FF0
10007A 20007A 100000 200000 100064 200064 400032 410064
000003
10007F 20007F 100040 200040 420040
10008C 20008C 1000C0 2000C0 4300C0
100080 200080 100003 200003 440003
100082 200082 10000A 20000A 45000B
100082 200082 100006 200006 45000B
000004
100020 500000 490000
10008E 3000EF 3000CD 3000AB 300089 300067 300045 300023 300001
100084 30005A
100023 200023 490001
10008E 20008E 500000
000005
100064 200064 4B0001
100066 200066 460000
100065 200065 460001
1000C8 500000 4B0000
000006
F00000

/* scope_ctrl.f */
scope_ctrl_cmd_pkg.sv
scope_ctrl_cfg_pkg.sv
cmd_receiver.sv
chain_relay.sv
acq_settings.sv
reply_sender.sv
scope_ctrl.sv
scope_ctrl_chk.sv
tb_scope_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, from the project root
verilator --binary --assert -Wno-fatal --top-module tb_scope_ctrl -f scope_ctrl.f \
	-o tb_scope_ctrl > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
(./obj_dir/tb_scope_ctrl || echo "SIMULATION FAILED") > sim.log 2>&1
cat sim.log
grep -q "SIMULATION FAILED" sim.log && { echo "run failed"; exit 1; } || { echo "run passed"; exit 0; }
